// ==== src/sbaskt_map_pkg.sv ====
// Memory map package for the ROM loader and SDRAM layout
`default_nettype none

package sbaskt_map_pkg;

    // Address widths
    localparam int SDRAM_AW = 22;   // 16-bit word addresses
    localparam int IOCTL_AW = 25;   // Download byte address

    // Region byte offsets, shared by the download stream and the SDRAM
    // Main CPU ROM sits at byte 0
    localparam logic [SDRAM_AW-1:0] SND_START = 22'h01_0000;
    localparam logic [SDRAM_AW-1:0] SCR_START = 22'h01_2000;
    localparam logic [SDRAM_AW-1:0] OBJ_START = 22'h01_A000;
    localparam logic [SDRAM_AW-1:0] PCM_START = 22'h02_A000;

    // Client address widths
    localparam int SCR_AW  = 13;    // 32-bit scroll tiles
    localparam int OBJ_AW  = 14;    // 32-bit objects
    localparam int SND_AW  = 13;    // Sound CPU bytes
    localparam int MAIN_AW = 16;    // Main CPU bytes

    localparam int N_SLOTS = 4;

endpackage

`default_nettype wire

// ==== src/sbaskt_bus_pkg.sv ====
// Bus package with the SDRAM request, read return and program write records
`default_nettype none

package sbaskt_bus_pkg;

    import sbaskt_map_pkg::*;

    // Read request from a slot or from the arbiter
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;  // Word address
    } sdram_rd_t;

    // Read return, two consecutive words
    typedef struct packed {
        logic [31:0] data;          // Word at addr in the low half
        logic        data_rdy;      // One-cycle strobe
    } sdram_ret_t;

    // Program write toward the SDRAM
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [7:0]          data;  // Same byte on both lanes
        logic [1:0]          mask;  // Active low, bit 0 is the low byte
        logic                we;    // Held until sdram_ack
    } prog_wr_t;

    typedef logic [$clog2(N_SLOTS)-1:0] slot_id_t;

    // Client payloads
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word32_t;

endpackage

`default_nettype wire

// ==== src/sbaskt_dwnld.sv ====
// ROM downloader that packs the byte stream into masked SDRAM program writes
`default_nettype none

module sbaskt_dwnld
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                downloading,
    input  wire logic [IOCTL_AW-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_dout,
    input  wire logic                ioctl_wr,
    input  wire logic                sdram_ack,
    output prog_wr_t                 prog
);

    logic [SDRAM_AW-1:0] low_addr;  // Region compare uses the low 22 bits
    logic [SDRAM_AW-1:0] pre_addr;  // Byte address without its lane bit
    logic [SDRAM_AW-1:0] map_addr;
    logic                in_scr;
    logic                in_obj;
    logic                take;

    logic [SDRAM_AW-1:0] addr_q;
    logic [7:0]          data_q;
    logic [1:0]          mask_q;
    logic                we_q;

    assign low_addr = ioctl_addr[SDRAM_AW-1:0];
    assign pre_addr = ioctl_addr[SDRAM_AW:1];
    assign in_scr   = (low_addr >= SCR_START) && (low_addr < OBJ_START);
    assign in_obj   = (low_addr >= OBJ_START) && (low_addr < PCM_START);
    assign take     = downloading && ioctl_wr;

    // Graphics ROMs are stored with their word address bits shuffled
    always_comb begin
        map_addr = pre_addr;
        if (in_scr) begin
            map_addr[0]   = ~pre_addr[3];
            map_addr[3:1] = pre_addr[2:0];
        end else if (in_obj) begin
            map_addr[0]   = ~pre_addr[3];
            map_addr[1]   = ~pre_addr[4];
            map_addr[5:2] = {pre_addr[5], pre_addr[2:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else if (take) begin
            we_q <= 1'b1;
        end else if (sdram_ack) begin
            we_q <= 1'b0;               // SDRAM took the byte
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= map_addr;
            data_q <= ioctl_dout;
            mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte goes high
        end
    end

    assign prog = '{addr: addr_q, data: data_q, mask: mask_q, we: we_q};

endmodule

`default_nettype wire

// ==== src/sbaskt_rom_slot.sv ====
// ROM slot with a one-word cache that requests the SDRAM on a miss
`default_nettype none

module sbaskt_rom_slot
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
#(
    parameter type                 slot_data_t = byte_t,
    parameter int                  AW          = 13,
    parameter logic [SDRAM_AW-1:0] OFFSET      = '0   // Byte offset of the region
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          downloading,
    input  wire logic          cs,
    input  wire logic [AW-1:0] addr,
    output logic               ok,
    output slot_data_t         data,
    output logic               req,
    output sdram_rd_t          rd_addr,
    input  wire sdram_ret_t    ret
);

    localparam bit IS_BYTE = ($bits(slot_data_t) == 8);

    logic [AW-1:0] widx;        // Client address in 32-bit word units
    logic [AW-1:0] tag;
    logic [AW-1:0] req_tag;     // Word being fetched
    logic          valid;
    logic          hit;
    logic          miss;
    logic [4:0]    lane_shift;
    word32_t       cache;

    assign widx       = IS_BYTE ? (addr >> 2) : addr;
    assign hit        = valid && (tag == widx);
    assign miss       = cs && !hit && !req;
    assign ok         = cs && hit;
    assign lane_shift = IS_BYTE ? {addr[1:0], 3'b000} : 5'd0;  // Little-endian byte pick
    assign data       = slot_data_t'(cache >> lane_shift);

    // Each cached word covers two SDRAM words
    assign rd_addr.addr = (OFFSET >> 1) + SDRAM_AW'({req_tag, 1'b0});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else begin
            if (ret.data_rdy) begin
                req <= 1'b0;
            end else if (miss && !downloading) begin
                req <= 1'b1;
            end

            if (downloading) begin
                valid <= 1'b0;          // ROM contents may change
            end else if (ret.data_rdy) begin
                valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            req_tag <= widx;
        end
        if (ret.data_rdy) begin
            cache <= ret.data;
            tag   <= req_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/sbaskt_rom_arb.sv ====
// Fixed-priority arbiter sharing the SDRAM read port among the ROM slots
`default_nettype none

module sbaskt_rom_arb
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               downloading,
    input  wire logic [N_SLOTS-1:0] req,
    input  wire sdram_rd_t          rd_addr [N_SLOTS],
    output logic                    sdram_req,
    output logic [SDRAM_AW-1:0]     sdram_addr,
    input  wire logic               sdram_ack,
    input  wire sdram_ret_t         sdram_ret,
    output sdram_ret_t              slot_ret [N_SLOTS]
);

    logic     busy;     // A read is in flight
    logic     grant;
    slot_id_t gnt;      // Slot that owns the current read
    slot_id_t sel;

    // Lowest index wins
    always_comb begin
        sel = '0;
        for (int i = N_SLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                sel = slot_id_t'(i);
            end
        end
    end

    assign grant = !busy && !downloading && (|req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            sdram_req <= 1'b0;
            gnt       <= '0;
        end else if (grant) begin
            busy      <= 1'b1;
            sdram_req <= 1'b1;
            gnt       <= sel;
        end else if (busy) begin
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (sdram_ret.data_rdy) begin
                busy <= 1'b0;       // Free for a new grant next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            sdram_addr <= rd_addr[sel].addr;
        end
    end

    // Data goes to everybody, the strobe only to the owner
    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            slot_ret[i].data     = sdram_ret.data;
            slot_ret[i].data_rdy = sdram_ret.data_rdy && busy && (gnt == slot_id_t'(i));
        end
    end

endmodule

`default_nettype wire

// ==== src/sbaskt_rom.sv ====
// ROM subsystem top with the downloader, four client slots and the SDRAM arbiter
`default_nettype none

module sbaskt_rom
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    // ROM download
    input  wire logic                downloading,
    input  wire logic [IOCTL_AW-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_dout,
    input  wire logic                ioctl_wr,
    output prog_wr_t                 prog,
    // Scroll tiles
    input  wire logic                scr_cs,
    input  wire logic [SCR_AW-1:0]   scr_addr,
    output logic                     scr_ok,
    output word32_t                  scr_data,
    // Objects
    input  wire logic                obj_cs,
    input  wire logic [OBJ_AW-1:0]   obj_addr,
    output logic                     obj_ok,
    output word32_t                  obj_data,
    // Sound CPU
    input  wire logic                snd_cs,
    input  wire logic [SND_AW-1:0]   snd_addr,
    output logic                     snd_ok,
    output byte_t                    snd_data,
    // Main CPU
    input  wire logic                main_cs,
    input  wire logic [MAIN_AW-1:0]  main_addr,
    output logic                     main_ok,
    output byte_t                    main_data,
    // SDRAM
    output logic                     sdram_req,
    output logic [SDRAM_AW-1:0]      sdram_addr,
    input  wire logic                sdram_ack,
    input  wire sdram_ret_t          sdram_ret
);

    logic [N_SLOTS-1:0] slot_req;
    sdram_rd_t          slot_rd  [N_SLOTS];
    sdram_ret_t         slot_ret [N_SLOTS];

    sbaskt_dwnld u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),   // Reads are idle while downloading
        .prog        ( prog        )
    );

    // Slot 0 has the highest priority
    sbaskt_rom_slot #(.slot_data_t(byte_t), .AW(MAIN_AW), .OFFSET('0)) u_main (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( main_cs      ),
        .addr        ( main_addr    ),
        .ok          ( main_ok      ),
        .data        ( main_data    ),
        .req         ( slot_req[0]  ),
        .rd_addr     ( slot_rd[0]   ),
        .ret         ( slot_ret[0]  )
    );

    sbaskt_rom_slot #(.slot_data_t(byte_t), .AW(SND_AW), .OFFSET(SND_START)) u_snd (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( snd_cs       ),
        .addr        ( snd_addr     ),
        .ok          ( snd_ok       ),
        .data        ( snd_data     ),
        .req         ( slot_req[1]  ),
        .rd_addr     ( slot_rd[1]   ),
        .ret         ( slot_ret[1]  )
    );

    sbaskt_rom_slot #(.slot_data_t(word32_t), .AW(OBJ_AW), .OFFSET(OBJ_START)) u_obj (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( obj_cs       ),
        .addr        ( obj_addr     ),
        .ok          ( obj_ok       ),
        .data        ( obj_data     ),
        .req         ( slot_req[2]  ),
        .rd_addr     ( slot_rd[2]   ),
        .ret         ( slot_ret[2]  )
    );

    sbaskt_rom_slot #(.slot_data_t(word32_t), .AW(SCR_AW), .OFFSET(SCR_START)) u_scr (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( scr_cs       ),
        .addr        ( scr_addr     ),
        .ok          ( scr_ok       ),
        .data        ( scr_data     ),
        .req         ( slot_req[3]  ),
        .rd_addr     ( slot_rd[3]   ),
        .ret         ( slot_ret[3]  )
    );

    sbaskt_rom_arb u_arb (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .req         ( slot_req     ),
        .rd_addr     ( slot_rd      ),
        .sdram_req   ( sdram_req    ),
        .sdram_addr  ( sdram_addr   ),
        .sdram_ack   ( sdram_ack    ),
        .sdram_ret   ( sdram_ret    ),
        .slot_ret    ( slot_ret     )
    );

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
// Clock generator for the ROM subsystem testbench
`default_nettype none

module tb_clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

endmodule

`default_nettype wire

// ==== verification/sbaskt_sdram_model.sv ====
// SDRAM model that stores program writes and answers reads after a variable delay
`default_nettype none

module sbaskt_sdram_model
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire prog_wr_t            prog,
    input  wire logic                sdram_req,
    input  wire logic [SDRAM_AW-1:0] sdram_addr,
    output logic                     sdram_ack,
    output sdram_ret_t               sdram_ret
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [0:131071];
    logic [31:0] lfsr_q;
    logic [16:0] rd_a;
    logic        wr_busy;
    logic        rd_busy;
    int          wait_cnt;

    // Fibonacci LFSR, one step per bit taken
    function automatic logic [31:0] pick_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    initial begin
        lfsr_q = 32'h72ba_e572;
        for (int i = 0; i < 131072; i++) begin
            mem[i] = 16'(i) ^ {i[16], 15'h0};
        end
    end

    always @(posedge clk) begin
        sdram_ack          <= 1'b0;
        sdram_ret.data_rdy <= 1'b0;
        if (!rst_n) begin
            wr_busy  <= 1'b0;
            rd_busy  <= 1'b0;
            wait_cnt <= 0;
        end else if (wr_busy) begin
            if (wait_cnt <= 1) begin
                if (!prog.mask[0]) mem[prog.addr[16:0]][7:0]  <= prog.data;
                if (!prog.mask[1]) mem[prog.addr[16:0]][15:8] <= prog.data;
                sdram_ack <= 1'b1;
                wr_busy   <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (rd_busy) begin
            if (wait_cnt <= 1) begin
                sdram_ret.data     <= {mem[rd_a + 17'd1], mem[rd_a]};  // Next word on top
                sdram_ret.data_rdy <= 1'b1;
                rd_busy            <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (prog.we && !sdram_ack) begin
            wr_busy  <= 1'b1;
            wait_cnt <= 1 + int'(pick_bits(2)) % 3;     // 1 to 3 cycles
        end else if (sdram_req && !sdram_ack) begin
            sdram_ack <= 1'b1;
            rd_a      <= sdram_addr[16:0];
            rd_busy   <= 1'b1;
            wait_cnt  <= 2 + int'(pick_bits(3)) % 5;    // 2 to 6 cycles
        end
    end

endmodule

`default_nettype wire

// ==== verification/sbaskt_rom_checker.sv ====
// Protocol assertions for the SDRAM read arbiter
`default_nettype none

module sbaskt_rom_checker
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
(
    input wire logic               clk,
    input wire logic               rst_n,
    input wire logic               downloading,
    input wire logic [N_SLOTS-1:0] req,
    input wire logic               sdram_req,
    input wire logic               sdram_ack,
    input wire sdram_ret_t         sdram_ret,
    input wire sdram_ret_t         slot_ret [N_SLOTS]
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [N_SLOTS-1:0] rdy;

    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            rdy[i] = slot_ret[i].data_rdy;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before sdram_ack");

    // A new read may only start from a cycle outside the download
    a_no_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(downloading))
        else $error("read granted during download");

    // The returned word belongs to exactly one slot that is still waiting
    a_one_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_ret.data_rdy |-> $onehot(rdy) && ((rdy & ~req) == '0))
        else $error("data_rdy did not reach exactly one requesting slot");

endmodule

bind sbaskt_rom_arb sbaskt_rom_checker u_checker (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .downloading ( downloading ),
    .req         ( req         ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .sdram_ret   ( sdram_ret   ),
    .slot_ret    ( slot_ret    )
);

`default_nettype wire

// ==== verification/tb_sbaskt_rom.sv ====
// Testbench for the ROM subsystem with download, read and contention tests
`default_nettype none

module tb_sbaskt_rom
    import sbaskt_map_pkg::*, sbaskt_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_BYTES = 321;
    localparam int N_READS = 60;
    localparam int LIMIT   = 400 + N_BYTES * 8 + N_READS * 60;

    logic                clk;
    logic                rst_n;
    logic                downloading;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic [3:0]          cs_v;      // Main, sound, objects, scroll
    logic [MAIN_AW-1:0]  main_addr;
    logic [SND_AW-1:0]   snd_addr;
    logic [OBJ_AW-1:0]   obj_addr;
    logic [SCR_AW-1:0]   scr_addr;
    logic                main_ok, snd_ok, obj_ok, scr_ok;
    byte_t               main_data, snd_data;
    word32_t             obj_data, scr_data;
    prog_wr_t            prog;
    logic                sdram_req, sdram_ack;
    logic [SDRAM_AW-1:0] sdram_addr;
    sdram_ret_t          sdram_ret;

    logic [7:0]  shadow [0:262143];     // Expected SDRAM bytes
    logic [31:0] lfsr_q = 32'h72ba_e572;
    int          cycles = 0;

    tb_clk_gen u_clk (.clk(clk));

    sbaskt_rom u_sbaskt_rom (
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr), .prog(prog),
        .scr_cs(cs_v[3]), .scr_addr(scr_addr), .scr_ok(scr_ok), .scr_data(scr_data),
        .obj_cs(cs_v[2]), .obj_addr(obj_addr), .obj_ok(obj_ok), .obj_data(obj_data),
        .snd_cs(cs_v[1]), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
        .main_cs(cs_v[0]), .main_addr(main_addr), .main_ok(main_ok), .main_data(main_data),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .sdram_ret(sdram_ret)
    );

    sbaskt_sdram_model u_sdram (
        .clk(clk), .rst_n(rst_n), .prog(prog), .sdram_req(sdram_req),
        .sdram_addr(sdram_addr), .sdram_ack(sdram_ack), .sdram_ret(sdram_ret)
    );

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Expected SDRAM word address of a download byte
    function automatic logic [SDRAM_AW-1:0] ref_word(input logic [IOCTL_AW-1:0] a);
        logic [SDRAM_AW-1:0] o;
        logic [SDRAM_AW-1:0] w;
        o = a[SDRAM_AW:1];
        w = o;
        if (a[SDRAM_AW-1:0] >= SCR_START && a[SDRAM_AW-1:0] < OBJ_START) begin
            w[0] = ~o[3];
            w[1] = o[0];
            w[2] = o[1];
            w[3] = o[2];
        end else if (a[SDRAM_AW-1:0] >= OBJ_START && a[SDRAM_AW-1:0] < PCM_START) begin
            w[0] = ~o[3];
            w[1] = ~o[4];
            w[2] = o[0];
            w[3] = o[1];
            w[4] = o[2];
            w[5] = o[5];
        end
        return w;
    endfunction

    // Four SDRAM bytes from a byte address, little-endian
    function automatic logic [31:0] exp_word(input int base);
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic download_byte(input logic [IOCTL_AW-1:0] a, input logic [7:0] d);
        logic [SDRAM_AW-1:0] w;
        logic [15:0]         word;
        w = ref_word(a);
        shadow[18'({w, a[0]})] = d;
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (prog.we) @(negedge clk);
        word = u_sdram.mem[w[16:0]];
        check_val("program write", 32'(a[0] ? word[15:8] : word[7:0]), 32'(d));
    endtask

    task automatic download_block(input int base, input int len);
        for (int i = 0; i < len; i++) begin
            download_byte(IOCTL_AW'(base + i), 8'(rand_bits(8)));
        end
    endtask

    // Holds cs until each active client has seen ok, then one cycle longer
    // On a repeated set every ok must stay high as long as its cs
    task automatic read_set(input logic [3:0] act, input logic [15:0] ma,
                            input logic [12:0] sa, input logic [13:0] oa,
                            input logic [12:0] ca, input logic expect_hit);
        logic [3:0] done;
        logic [3:0] ok_now;
        done = '0;
        @(negedge clk);
        main_addr = ma;
        snd_addr  = sa;
        obj_addr  = oa;
        scr_addr  = ca;
        cs_v      = act;
        while (cs_v != 4'b0) begin
            @(negedge clk);
            ok_now = {scr_ok, obj_ok, snd_ok, main_ok};
            if (expect_hit) check_val("repeat hit ok", 32'(ok_now), 32'(cs_v));
            for (int i = 0; i < 4; i++) begin
                if (done[i]) cs_v[i] = 1'b0;
                else if (ok_now[i]) done[i] = 1'b1;
            end
        end
    endtask

    // Every ok must carry the downloaded bytes of its address
    always @(posedge clk) begin
        if (rst_n) begin
            if (main_ok) begin
                check_val("main data", 32'(main_data), 32'(shadow[int'(main_addr)]));
            end
            if (snd_ok) begin
                check_val("sound data", 32'(snd_data),
                          32'(shadow[int'(SND_START) + int'(snd_addr)]));
            end
            if (obj_ok) begin
                check_val("object data", obj_data,
                          exp_word(int'(OBJ_START) + 4 * int'(obj_addr)));
            end
            if (scr_ok) begin
                check_val("scroll data", scr_data,
                          exp_word(int'(SCR_START) + 4 * int'(scr_addr)));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [15:0] ma;
        logic [12:0] sa;
        logic [13:0] oa;
        logic [12:0] ca;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        cs_v        = '0;
        main_addr   = '0;
        snd_addr    = '0;
        obj_addr    = '0;
        scr_addr    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        downloading = 1'b1;
        download_block(32'h1240, 64);
        download_block(int'(SND_START) + 32'h300, 64);
        download_block(int'(SCR_START) + 32'h400, 64);   // Two full reorder blocks
        download_block(int'(OBJ_START) + 32'h800, 128);
        @(negedge clk);
        downloading = 1'b0;
        for (int r = 0; r < 8; r++) begin
            ma = 16'h1240 + 16'(rand_bits(6));
            sa = 13'h0300 + 13'(rand_bits(6));
            oa = 14'h0200 + 14'(rand_bits(5));
            ca = 13'h0100 + 13'(rand_bits(4));
            read_set(4'b0001, ma, sa, oa, ca, 1'b0);
            read_set(4'b0010, ma, sa, oa, ca, 1'b0);
            read_set(4'b0100, ma, sa, oa, ca, 1'b0);
            read_set(4'b1000, ma, sa, oa, ca, 1'b0);
            ma = 16'h1240 + 16'(rand_bits(6));
            sa = 13'h0300 + 13'(rand_bits(6));
            oa = 14'h0200 + 14'(rand_bits(5));
            ca = 13'h0100 + 13'(rand_bits(4));
            read_set(4'b1111, ma, sa, oa, ca, 1'b0);
            read_set(4'b1111, ma, sa, oa, ca, 1'b1);
        end
        // Cache a byte, overwrite it by a new download, read it back
        read_set(4'b0001, 16'h1245, sa, oa, ca, 1'b0);
        @(negedge clk);
        downloading = 1'b1;
        download_byte(25'h1245, ~shadow[32'h1245]);
        @(negedge clk);
        downloading = 1'b0;
        read_set(4'b0001, 16'h1245, sa, oa, ca, 1'b0);
        repeat (4) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sbaskt_rom.f ====
src/sbaskt_map_pkg.sv
src/sbaskt_bus_pkg.sv
src/sbaskt_dwnld.sv
src/sbaskt_rom_slot.sv
src/sbaskt_rom_arb.sv
src/sbaskt_rom.sv
verification/tb_clk_gen.sv
verification/sbaskt_sdram_model.sv
verification/sbaskt_rom_checker.sv
verification/tb_sbaskt_rom.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the ROM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sbaskt_rom -f sbaskt_rom.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
